// File: logic/rp_pkg.sv
// analog path shared definitions
`default_nettype none

package rp_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int adc_w     = 14;  // sample width
  localparam int adc_bus_w = 16;  // pin width, two lsbs reserved
  localparam int bus_w     = 32;  // sys bus data and address

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////
  localparam int n_regions     = 8;
  localparam int region_lsb    = 20;  // region field is addr[22:20]
  localparam int region_hk     = 0;
  localparam int region_router = 3;

  // offsets inside a region
  localparam logic [region_lsb-1:0] hk_id_off    = 'h00;  // read only
  localparam logic [region_lsb-1:0] hk_loop_off  = 'h04;  // bit 0
  localparam logic [region_lsb-1:0] hk_led_off   = 'h30;
  localparam logic [region_lsb-1:0] rt_src_a_off = 'h00;
  localparam logic [region_lsb-1:0] rt_src_b_off = 'h04;
  localparam logic [region_lsb-1:0] rt_lvl_a_off = 'h08;
  localparam logic [region_lsb-1:0] rt_lvl_b_off = 'h0C;

  localparam logic [bus_w-1:0] rp_id           = 32'h5250_0114;
  localparam logic [1:0]       adc_clk_sel_val = 2'b10;  // adc clock gen off
  localparam logic             adc_cdcs_val    = 1'b1;   // stabilizer on

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////
  typedef logic signed [adc_w-1:0] sample_t;

  typedef struct packed {
    sample_t a;  // channel a
    sample_t b;  // channel b
  } sample_pair_t;

  typedef struct packed {
    logic [bus_w-1:0] addr;
    logic [bus_w-1:0] wdata;
    logic [3:0]       sel;    // byte lanes
    logic             wen;    // one cycle strobe
    logic             ren;    // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [bus_w-1:0] rdata;
    logic             err;
    logic             ack;
  } sys_rsp_t;

  // dac channel source, 3 acts as off
  typedef enum logic [1:0] {
    src_off   = 2'd0,
    src_adc   = 2'd1,
    src_level = 2'd2
  } out_src_t;

endpackage

`default_nettype wire

// File: logic/adc_frontend.sv
// adc capture and loopback
`default_nettype none

module adc_frontend (
  input  wire logic                          adc_clk,
  input  wire logic                          arst_n_i,
  input  wire logic [rp_pkg::adc_bus_w-1:0]  adc_dat_a_i,  // raw pins ch a
  input  wire logic [rp_pkg::adc_bus_w-1:0]  adc_dat_b_i,  // raw pins ch b
  input  wire logic                          loop_i,       // digital loopback
  input  wire rp_pkg::sample_pair_t          loop_pair_i,  // dac bound samples
  output rp_pkg::sample_pair_t               adc_pair_o
);

  logic [rp_pkg::adc_w-1:0] raw_a;  // pin register, neg slope code
  logic [rp_pkg::adc_w-1:0] raw_b;
  rp_pkg::sample_pair_t     conv;   // two's complement

  //////////////////////////////////////////////////
  // pin capture
  //////////////////////////////////////////////////
  // drop the two reserved lsbs
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      raw_a <= 14'h1FFF;  // mid scale, converts to 0
      raw_b <= 14'h1FFF;
    end
    else
    begin
      raw_a <= adc_dat_a_i[rp_pkg::adc_bus_w-1 -: rp_pkg::adc_w];
      raw_b <= adc_dat_b_i[rp_pkg::adc_bus_w-1 -: rp_pkg::adc_w];
    end
  end

  // keep sign, flip magnitude bits
  assign conv.a = rp_pkg::sample_t'({raw_a[rp_pkg::adc_w-1], ~raw_a[rp_pkg::adc_w-2:0]});
  assign conv.b = rp_pkg::sample_t'({raw_b[rp_pkg::adc_w-1], ~raw_b[rp_pkg::adc_w-2:0]});

  assign adc_pair_o = loop_i ? loop_pair_i : conv;  // loopback overrides adc

endmodule

`default_nettype wire

// File: logic/sys_bus_decoder.sv
// system bus region decoder
`default_nettype none

module sys_bus_decoder (
  input  wire rp_pkg::sys_req_t  sys_req_i,  // from master
  input  wire rp_pkg::sys_rsp_t  hk_rsp_i,   // region 0 slave
  input  wire rp_pkg::sys_rsp_t  rt_rsp_i,   // region 3 slave
  output rp_pkg::sys_req_t       hk_req_o,
  output rp_pkg::sys_req_t       rt_req_o,
  output rp_pkg::sys_rsp_t       sys_rsp_o
);

  logic [$clog2(rp_pkg::n_regions)-1:0] region;    // addr[22:20]
  logic [rp_pkg::n_regions-1:0]         cs;        // one hot region select
  rp_pkg::sys_rsp_t                     empty_rsp; // idle region answer
  rp_pkg::sys_rsp_t                     rsp_arr [rp_pkg::n_regions];

  //////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////
  assign region = sys_req_i.addr[rp_pkg::region_lsb +: $clog2(rp_pkg::n_regions)];
  assign cs     = rp_pkg::n_regions'(1) << region;

  // address, data and byte lanes go everywhere, strobes only to the hit
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & cs[rp_pkg::region_hk];
    hk_req_o.ren = sys_req_i.ren & cs[rp_pkg::region_hk];
    rt_req_o     = sys_req_i;
    rt_req_o.wen = sys_req_i.wen & cs[rp_pkg::region_router];
    rt_req_o.ren = sys_req_i.ren & cs[rp_pkg::region_router];
  end

  //////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////
  // empty regions: always acked, read 0, never err
  assign empty_rsp.rdata = '0;
  assign empty_rsp.err   = 1'b0;
  assign empty_rsp.ack   = 1'b1;

  always_comb
  begin
    for (int i = 0; i < rp_pkg::n_regions; i++)
    begin
      rsp_arr[i] = empty_rsp;  // constant responders
    end
    rsp_arr[rp_pkg::region_hk]     = hk_rsp_i;
    rsp_arr[rp_pkg::region_router] = rt_rsp_i;
  end

  // combinational return path, master holds addr until ack
  assign sys_rsp_o = rsp_arr[region];

endmodule

`default_nettype wire

// File: logic/housekeeping_regs.sv
// housekeeping register bank
`default_nettype none

module housekeeping_regs (
  input  wire logic              adc_clk,
  input  wire logic              arst_n_i,
  input  wire rp_pkg::sys_req_t  req_i,   // region 0 strobes only
  output rp_pkg::sys_rsp_t       rsp_o,
  output logic                   loop_o,  // digital loopback enable
  output logic [7:0]             led_o
);

  logic [rp_pkg::region_lsb-1:0] off;      // offset in region
  logic                          hit_id;
  logic                          hit_loop;
  logic                          hit_led;
  logic                          mapped;
  logic                          wr;       // write with any lane on
  logic [rp_pkg::bus_w-1:0]      rd_mux;
  logic [rp_pkg::bus_w-1:0]      rdata_q;
  logic                          ack_q;
  logic                          err_q;

  //////////////////////////////////////////////////
  // offset decode
  //////////////////////////////////////////////////
  assign off      = req_i.addr[rp_pkg::region_lsb-1:0];
  assign hit_id   = (off == rp_pkg::hk_id_off);
  assign hit_loop = (off == rp_pkg::hk_loop_off);
  assign hit_led  = (off == rp_pkg::hk_led_off);
  assign mapped   = hit_id | hit_loop | hit_led;
  assign wr       = req_i.wen & (|req_i.sel);

  always_comb
  begin
    rd_mux = '0;                                  // unmapped reads 0
    if (hit_id)   rd_mux = rp_pkg::rp_id;
    if (hit_loop) rd_mux = {31'b0, loop_o};
    if (hit_led)  rd_mux = {24'b0, led_o};
  end

  // control, answer one cycle after strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_o <= 1'b0;
      led_o  <= 8'h00;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      err_q <= (req_i.wen | req_i.ren) & ~mapped;  // bad offset
      if (wr && hit_loop) loop_o <= req_i.wdata[0];
      if (wr && hit_led)  led_o  <= req_i.wdata[7:0];
      // id is read only, writes dropped
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren) rdata_q <= rd_mux;  // held until next read
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

`default_nettype wire

// File: logic/output_router.sv
// dac source router
`default_nettype none

module output_router (
  input  wire logic                  adc_clk,
  input  wire logic                  arst_n_i,
  input  wire rp_pkg::sys_req_t      req_i,       // region 3 strobes only
  input  wire rp_pkg::sample_pair_t  adc_pair_i,  // from frontend
  output rp_pkg::sys_rsp_t           rsp_o,
  output rp_pkg::sample_pair_t       dac_pair_o   // to serializer and loopback
);

  logic [rp_pkg::region_lsb-1:0] off;
  logic                          hit_src_a;
  logic                          hit_src_b;
  logic                          hit_lvl_a;
  logic                          hit_lvl_b;
  logic                          mapped;
  logic                          wr;
  logic [rp_pkg::bus_w-1:0]      rd_mux;
  logic [rp_pkg::bus_w-1:0]      rdata_q;
  logic                          ack_q;
  logic                          err_q;
  rp_pkg::out_src_t              src_a;   // per channel select
  rp_pkg::out_src_t              src_b;
  rp_pkg::sample_t               lvl_a;   // dc levels
  rp_pkg::sample_t               lvl_b;

  // one channel's pick, 3 falls to off
  function automatic rp_pkg::sample_t pick(rp_pkg::out_src_t src, rp_pkg::sample_t adc,
                                           rp_pkg::sample_t lvl);
    case (src)
      rp_pkg::src_adc:   return adc;
      rp_pkg::src_level: return lvl;
      default:           return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // register bank
  //////////////////////////////////////////////////
  assign off       = req_i.addr[rp_pkg::region_lsb-1:0];
  assign hit_src_a = (off == rp_pkg::rt_src_a_off);
  assign hit_src_b = (off == rp_pkg::rt_src_b_off);
  assign hit_lvl_a = (off == rp_pkg::rt_lvl_a_off);
  assign hit_lvl_b = (off == rp_pkg::rt_lvl_b_off);
  assign mapped    = hit_src_a | hit_src_b | hit_lvl_a | hit_lvl_b;
  assign wr        = req_i.wen & (|req_i.sel);

  always_comb
  begin
    rd_mux = '0;
    if (hit_src_a) rd_mux = {30'b0, src_a};
    if (hit_src_b) rd_mux = {30'b0, src_b};
    if (hit_lvl_a) rd_mux = {18'b0, lvl_a};  // raw 14 bits, no sign ext
    if (hit_lvl_b) rd_mux = {18'b0, lvl_b};
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      src_a      <= rp_pkg::src_off;
      src_b      <= rp_pkg::src_off;
      lvl_a      <= '0;
      lvl_b      <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      dac_pair_o <= '0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      err_q <= (req_i.wen | req_i.ren) & ~mapped;
      if (wr && hit_src_a) src_a <= rp_pkg::out_src_t'(req_i.wdata[1:0]);
      if (wr && hit_src_b) src_b <= rp_pkg::out_src_t'(req_i.wdata[1:0]);
      if (wr && hit_lvl_a) lvl_a <= rp_pkg::sample_t'(req_i.wdata[rp_pkg::adc_w-1:0]);
      if (wr && hit_lvl_b) lvl_b <= rp_pkg::sample_t'(req_i.wdata[rp_pkg::adc_w-1:0]);
      // one cycle through the router
      dac_pair_o.a <= pick(src_a, adc_pair_i.a, lvl_a);
      dac_pair_o.b <= pick(src_b, adc_pair_i.b, lvl_b);
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren) rdata_q <= rd_mux;
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

`default_nettype wire

// File: logic/dac_serializer.sv
// dac code conversion and interleave
`default_nettype none

module dac_serializer (
  input  wire logic                  adc_clk,
  input  wire logic                  arst_n_i,
  input  wire rp_pkg::sample_pair_t  dac_pair_i,  // two's complement
  output logic [rp_pkg::adc_w-1:0]   dac_dat_o,   // interleaved code
  output logic                       dac_sel_o,   // low a, high b
  output logic                       dac_rst_o    // active high
);

  logic [rp_pkg::adc_w-1:0] code_a;  // neg slope dac codes
  logic [rp_pkg::adc_w-1:0] code_b;

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      code_a    <= 14'h1FFF;  // zero output
      code_b    <= 14'h1FFF;
      dac_sel_o <= 1'b0;
      dac_rst_o <= 1'b1;      // held in reset
    end
    else
    begin
      // sign kept, magnitude flipped
      code_a    <= {dac_pair_i.a[rp_pkg::adc_w-1], ~dac_pair_i.a[rp_pkg::adc_w-2:0]};
      code_b    <= {dac_pair_i.b[rp_pkg::adc_w-1], ~dac_pair_i.b[rp_pkg::adc_w-2:0]};
      dac_sel_o <= ~dac_sel_o;  // each channel at half rate
      dac_rst_o <= 1'b0;        // drops on first edge after release
    end
  end

  //////////////////////////////////////////////////
  // channel interleave
  //////////////////////////////////////////////////
  // no 2x clock, so one word per adc_clk
  always_comb
  begin
    if (dac_sel_o)
      dac_dat_o = code_b;
    else
      dac_dat_o = code_a;
  end

endmodule

`default_nettype wire

// File: logic/rp_top.sv
// analog board top level
`default_nettype none

module rp_top (
  input  wire logic                          adc_clk,
  input  wire logic                          arst_n_i,
  input  wire logic [rp_pkg::adc_bus_w-1:0]  adc_dat_a_i,  // adc ch a pins
  input  wire logic [rp_pkg::adc_bus_w-1:0]  adc_dat_b_i,  // adc ch b pins
  input  wire rp_pkg::sys_req_t              sys_req_i,    // bus master
  output rp_pkg::sys_rsp_t                   sys_rsp_o,
  output logic [rp_pkg::adc_w-1:0]           dac_dat_o,
  output logic                               dac_sel_o,
  output logic                               dac_rst_o,
  output logic [7:0]                         led_o,
  output logic [1:0]                         adc_clk_o,    // adc clock source
  output logic                               adc_cdcs_o    // duty cycle stabilizer
);

  rp_pkg::sample_pair_t adc_pair;      // adc side, two's complement
  rp_pkg::sample_pair_t dac_pair;      // router out
  rp_pkg::sys_req_t     hk_req;
  rp_pkg::sys_req_t     rt_req;
  rp_pkg::sys_rsp_t     hk_rsp;
  rp_pkg::sys_rsp_t     rt_rsp;
  logic                 digital_loop;

  // fixed pin levels
  assign adc_clk_o  = rp_pkg::adc_clk_sel_val;
  assign adc_cdcs_o = rp_pkg::adc_cdcs_val;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////
  adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (digital_loop),
    .loop_pair_i (dac_pair),      // loopback path
    .adc_pair_o  (adc_pair)
  );

  //////////////////////////////////////////////////
  // bus and processing
  //////////////////////////////////////////////////
  sys_bus_decoder u_dec (
    .sys_req_i (sys_req_i),
    .hk_rsp_i  (hk_rsp),
    .rt_rsp_i  (rt_rsp),
    .hk_req_o  (hk_req),
    .rt_req_o  (rt_req),
    .sys_rsp_o (sys_rsp_o)
  );

  housekeeping_regs u_hk (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .req_i    (hk_req),
    .rsp_o    (hk_rsp),
    .loop_o   (digital_loop),
    .led_o    (led_o)
  );

  output_router u_rt (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .req_i      (rt_req),
    .adc_pair_i (adc_pair),
    .rsp_o      (rt_rsp),
    .dac_pair_o (dac_pair)
  );

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////
  dac_serializer u_dac (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .dac_pair_i (dac_pair),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o),
    .dac_rst_o  (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: tests/rp_top_tb.sv
// analog board testbench
`default_nettype none

module rp_top_tb;

  localparam int          planned_cycles = 300;           // rough length of all tests
  localparam logic [31:0] hk_base        = 32'h0000_0000; // region 0
  localparam logic [31:0] rt_base        = 32'h0030_0000; // region 3
  localparam logic [31:0] empty_base     = 32'h0050_0000; // region 5, no slave

  logic             adc_clk = 1'b0;
  logic             arst_n_i;
  logic [15:0]      adc_a;
  logic [15:0]      adc_b;
  rp_pkg::sys_req_t req;
  rp_pkg::sys_rsp_t rsp;
  logic [13:0]      dac_dat;
  logic             dac_sel;
  logic             dac_rst;
  logic [7:0]       led;
  logic [1:0]       adc_clk_sel;
  logic             adc_cdcs;
  logic [2:0]       region;       // addr[22:20] of the current request
  int               errors = 0;
  int               checks = 0;

  always #5 adc_clk = ~adc_clk;  // period 10

  rp_top dut (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .sys_req_i   (req),
    .sys_rsp_o   (rsp),
    .dac_dat_o   (dac_dat),
    .dac_sel_o   (dac_sel),
    .dac_rst_o   (dac_rst),
    .led_o       (led),
    .adc_clk_o   (adc_clk_sel),
    .adc_cdcs_o  (adc_cdcs)
  );

  assign region = req.addr[rp_pkg::region_lsb +: 3];

  // outputs parked while reset is held
  reset_state: assert property (@(negedge adc_clk) !arst_n_i |->
                 (dac_rst && !dac_sel && dac_dat == 14'h1FFF && led == 8'h00))
    else
    begin
      errors++;
      $display("[ERROR] reset dac_rst_o 0x%0h dac_sel_o 0x%0h dac_dat_o 0x%0h led_o 0x%0h",
               dac_rst, dac_sel, dac_dat, led);
    end

  // register slaves ack one cycle after the strobe, empty regions always
  ack_timing: assert property (@(negedge adc_clk) disable iff (!arst_n_i)
                rsp.ack == ((region == rp_pkg::region_hk || region == rp_pkg::region_router) ?
                            $past(req.wen | req.ren) : 1'b1))
    else
    begin
      errors++;
      $display("[ERROR] sys_rsp_o ack 0x%0h addr 0x%0h", rsp.ack, req.addr);
    end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    value_ok: assert (got === exp)
      else
      begin
        errors++;
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      end
  endtask

  task automatic wait_ack();
    @(negedge adc_clk);                       // sampled away from the edge
    while (!rsp.ack) @(negedge adc_clk);
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    req.addr  <= addr;
    req.wdata <= data;
    req.sel   <= 4'hF;
    req.wen   <= 1'b1;  // one cycle strobe
    @(posedge adc_clk);
    req.wen <= 1'b0;
    wait_ack();         // addr held until here
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(posedge adc_clk);
    req.addr <= addr;
    req.ren  <= 1'b1;
    @(posedge adc_clk);
    req.ren <= 1'b0;
    wait_ack();
    data = rsp.rdata;
    err  = rsp.err;
  endtask

  task automatic drive_pins();
    logic [15:0] a;
    logic [15:0] b;
    a = $urandom;
    b = $urandom;
    @(posedge adc_clk);
    adc_a <= a;
    adc_b <= b;
  endtask

  // both words once the pipeline has settled
  task automatic capture_dac(output logic [13:0] word_a, output logic [13:0] word_b);
    repeat (8) @(posedge adc_clk);
    repeat (2)
    begin
      @(negedge adc_clk);
      if (dac_sel) word_b = dac_dat;  // high selects b
      else         word_a = dac_dat;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial
  begin
    logic [31:0] rd;
    logic        err;
    logic [13:0] wa;
    logic [13:0] wb;
    logic [13:0] hold_a;
    logic [13:0] hold_b;
    logic [13:0] lvl_a;
    logic [13:0] lvl_b;
    logic [7:0]  led_val;
    void'($urandom(27));
    arst_n_i = 1'b0;
    req      = '0;
    adc_a    = '0;
    adc_b    = '0;
    repeat (2) @(posedge adc_clk);
    arst_n_i <= 1'b1;
    @(negedge adc_clk);
    compare("dac_rst_o", dac_rst, 1);  // still high until next edge
    compare("dac_sel_o", dac_sel, 0);
    compare("dac_dat_o", dac_dat, 14'h1FFF);
    @(negedge adc_clk);
    compare("dac_rst_o", dac_rst, 0);
    compare("adc_clk_o", adc_clk_sel, 2'b10);
    compare("adc_cdcs_o", adc_cdcs, 1);
    // register access
    read_reg(hk_base + rp_pkg::hk_id_off, rd, err);
    compare("rdata id", rd, rp_pkg::rp_id);
    compare("err id", err, 0);
    led_val = $urandom;
    write_reg(hk_base + rp_pkg::hk_led_off, {24'b0, led_val});
    read_reg(hk_base + rp_pkg::hk_led_off, rd, err);
    compare("rdata led", rd, {24'b0, led_val});
    compare("led_o", led, led_val);
    read_reg(empty_base + 32'h10, rd, err);
    compare("rdata region 5", rd, 0);
    compare("err region 5", err, 0);
    read_reg(hk_base + 32'h08, rd, err);   // hole in the map
    compare("err unmapped", err, 1);
    // adc straight through
    write_reg(rt_base + rp_pkg::rt_src_a_off, 32'd1);
    write_reg(rt_base + rp_pkg::rt_src_b_off, 32'd1);
    read_reg(rt_base + rp_pkg::rt_src_a_off, rd, err);
    compare("rdata src a", rd, 1);
    repeat (4)
    begin
      drive_pins();
      capture_dac(wa, wb);
      compare("dac_dat_o a", wa, adc_a[15:2]);
      compare("dac_dat_o b", wb, adc_b[15:2]);
    end
    // dc levels
    lvl_a = $urandom;
    lvl_b = $urandom;
    write_reg(rt_base + rp_pkg::rt_lvl_a_off, {18'b0, lvl_a});
    write_reg(rt_base + rp_pkg::rt_lvl_b_off, {18'b0, lvl_b});
    read_reg(rt_base + rp_pkg::rt_lvl_b_off, rd, err);
    compare("rdata lvl b", rd, {18'b0, lvl_b});
    write_reg(rt_base + rp_pkg::rt_src_a_off, 32'd2);
    write_reg(rt_base + rp_pkg::rt_src_b_off, 32'd2);
    capture_dac(wa, wb);
    compare("dac_dat_o a", wa, lvl_a ^ 14'h1FFF);  // magnitude bits flipped
    compare("dac_dat_o b", wb, lvl_b ^ 14'h1FFF);
    // off and the spare code
    write_reg(rt_base + rp_pkg::rt_src_a_off, 32'd0);
    write_reg(rt_base + rp_pkg::rt_src_b_off, 32'd3);
    read_reg(rt_base + rp_pkg::rt_src_b_off, rd, err);
    compare("rdata src b", rd, 3);
    capture_dac(wa, wb);
    compare("dac_dat_o a", wa, 14'h1FFF);
    compare("dac_dat_o b", wb, 14'h1FFF);
    // loopback freezes the words
    write_reg(rt_base + rp_pkg::rt_src_a_off, 32'd1);
    write_reg(rt_base + rp_pkg::rt_src_b_off, 32'd1);
    drive_pins();
    capture_dac(hold_a, hold_b);
    compare("dac_dat_o a", hold_a, adc_a[15:2]);
    compare("dac_dat_o b", hold_b, adc_b[15:2]);
    write_reg(hk_base + rp_pkg::hk_loop_off, 32'd1);
    read_reg(hk_base + rp_pkg::hk_loop_off, rd, err);
    compare("rdata loop", rd, 1);
    repeat (2)
    begin
      drive_pins();
      capture_dac(wa, wb);
      compare("dac_dat_o a", wa, hold_a);
      compare("dac_dat_o b", wb, hold_b);
    end
    write_reg(hk_base + rp_pkg::hk_loop_off, 32'd0);
    drive_pins();
    capture_dac(wa, wb);
    compare("dac_dat_o a", wa, adc_a[15:2]);  // pins again
    compare("dac_dat_o b", wb, adc_b[15:2]);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(20 * planned_cycles * 10);
    $display("timeout, the tests did not complete, errors %0d", errors);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/rp_pkg.sv
logic/adc_frontend.sv
logic/sys_bus_decoder.sv
logic/housekeeping_regs.sv
logic/output_router.sv
logic/dac_serializer.sv
logic/rp_top.sv
tests/rp_top_tb.sv
